// ==== design/flash_pkg.sv ====
`default_nettype none

package flash_pkg;

	// ############################
	// Bus and flash sizes
	// ############################
	localparam int FLASH_ADDR_W = 24;
	localparam int DATA_W       = 32;
	localparam int BYTE_W       = 8;
	localparam int SEL_W        = DATA_W / BYTE_W;
	localparam int BYTE_BIT_W   = $clog2(BYTE_W);      // Bit index within a byte
	localparam int WORD_BIT_W   = $clog2(DATA_W);      // Bit index within a word

	// ############################
	// Cache geometry
	// ############################
	localparam int LINE_WORDS  = 4;
	localparam int CACHE_LINES = 16;

	localparam int BYTE_OFF_W = $clog2(SEL_W);         // Ignored by the cache
	localparam int OFFSET_W   = $clog2(LINE_WORDS);
	localparam int INDEX_W    = $clog2(CACHE_LINES);
	localparam int TAG_W      = FLASH_ADDR_W - INDEX_W - OFFSET_W - BYTE_OFF_W;

	// Field positions inside a byte address
	localparam int OFFSET_LSB = BYTE_OFF_W;
	localparam int INDEX_LSB  = OFFSET_LSB + OFFSET_W;
	localparam int TAG_LSB    = INDEX_LSB + INDEX_W;

	// ############################
	// SPI read transaction
	// ############################
	localparam int                  SPI_CMD_W    = 8;
	localparam logic [SPI_CMD_W-1:0] SPI_CMD_READ = 8'h03;
	localparam int                  SPI_CLK_DIV  = 2;  // Sys clocks per SCLK half period
	localparam int                  SPI_DIV_W    = $clog2(SPI_CLK_DIV + 1);

	localparam int SPI_HDR_W     = SPI_CMD_W + FLASH_ADDR_W;       // Command plus address
	localparam int SPI_BITS      = SPI_HDR_W + LINE_WORDS * DATA_W;
	localparam int SPI_BIT_CNT_W = $clog2(SPI_BITS);

endpackage

`default_nettype wire

// ==== design/wb_flash_interface.sv ====
`default_nettype none

module wb_flash_interface import flash_pkg::*; (
	input  wire                     wb_clk_i,
	input  wire                     wb_rst_i,

	// Wishbone slave
	input  wire                     wb_cyc_i,
	input  wire                     wb_stb_i,
	input  wire                     wb_we_i,
	input  wire  [SEL_W-1:0]        wb_sel_i,
	input  wire  [FLASH_ADDR_W-1:0] wb_adr_i,
	input  wire  [DATA_W-1:0]       wb_data_i,
	output logic [DATA_W-1:0]       wb_data_o,
	output logic                    wb_ack_o,
	output logic                    wb_stall_o,
	output logic                    wb_err_o,

	// Flash cache
	output logic                    cache_rd_en_o,
	output logic [FLASH_ADDR_W-1:0] cache_addr_o,
	input  wire  [DATA_W-1:0]       cache_data_i,
	input  wire                     cache_busy_i
);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_READ,
		ST_REJECT,
		ST_FINISH
	} state_t;

	state_t                  state;
	logic [FLASH_ADDR_W-1:0] req_addr;
	logic                    req_valid;

	// Byte lanes and write data are not needed by a read-only flash
	assign req_valid = wb_cyc_i && wb_stb_i;

	// ############################
	// Request state machine
	// ############################
	always_ff @(posedge wb_clk_i) begin
		if (wb_rst_i) begin
			state      <= ST_IDLE;
			wb_ack_o   <= 1'b0;
			wb_err_o   <= 1'b0;
			wb_stall_o <= 1'b0;
			wb_data_o  <= '0;
		end else begin
			case (state)
				ST_IDLE: begin
					if (req_valid) begin
						wb_stall_o <= 1'b1;
						state      <= wb_we_i ? ST_REJECT : ST_READ;
					end
				end

				ST_READ: begin
					if (!cache_busy_i) begin   // Hit so data is valid this cycle
						wb_ack_o  <= 1'b1;
						wb_data_o <= cache_data_i;
						state     <= ST_FINISH;
					end
				end

				ST_REJECT: begin
					wb_err_o <= 1'b1;            // Flash is read-only
					state    <= ST_FINISH;
				end

				ST_FINISH: begin
					wb_ack_o   <= 1'b0;
					wb_err_o   <= 1'b0;
					wb_stall_o <= 1'b0;
					wb_data_o  <= '0;
					state      <= ST_IDLE;
				end

				default: begin
					wb_ack_o   <= 1'b0;
					wb_err_o   <= 1'b0;
					wb_stall_o <= 1'b0;
					state      <= ST_IDLE;
				end
			endcase
		end
	end

	// Address held for the whole request
	always_ff @(posedge wb_clk_i) begin
		if (state == ST_IDLE && req_valid)
			req_addr <= wb_adr_i;
	end

	assign cache_rd_en_o = (state == ST_READ);
	assign cache_addr_o  = req_addr;

endmodule

`default_nettype wire

// ==== design/flash_cache.sv ====
`default_nettype none

module flash_cache import flash_pkg::*; (
	input  wire                     wb_clk_i,
	input  wire                     wb_rst_i,

	// Request side
	input  wire                     rd_en_i,
	input  wire  [FLASH_ADDR_W-1:0] addr_i,
	input  wire                     flush_i,
	output logic [DATA_W-1:0]       data_o,
	output logic                    busy_o,

	// Line fill from the SPI reader
	output logic                    fill_start_o,
	output logic [FLASH_ADDR_W-1:0] fill_addr_o,
	input  wire                     word_valid_i,
	input  wire  [DATA_W-1:0]       word_data_i,
	input  wire                     fill_done_i
);

	// ############################
	// Storage
	// ############################
	logic [TAG_W-1:0]       tag_mem  [CACHE_LINES];
	logic [DATA_W-1:0]      data_mem [CACHE_LINES*LINE_WORDS];
	logic [CACHE_LINES-1:0] valid;

	logic [OFFSET_W-1:0] req_off;
	logic [INDEX_W-1:0]  req_idx;
	logic [TAG_W-1:0]    req_tag;
	logic                hit;

	logic                filling;
	logic                flush_pend;
	logic                flush_now;
	logic                start_fill;
	logic [OFFSET_W-1:0] fill_cnt;      // Next word slot of the line
	logic [INDEX_W-1:0]  fill_idx;

	// Address split without the byte bits
	assign req_off = addr_i[INDEX_LSB-1:OFFSET_LSB];
	assign req_idx = addr_i[TAG_LSB-1:INDEX_LSB];
	assign req_tag = addr_i[FLASH_ADDR_W-1:TAG_LSB];

	assign hit    = valid[req_idx] && (tag_mem[req_idx] == req_tag);
	assign busy_o = !hit;
	assign data_o = data_mem[{req_idx, req_off}];

	assign fill_idx   = fill_addr_o[TAG_LSB-1:INDEX_LSB];
	assign flush_now  = flush_i || flush_pend;
	assign start_fill = !filling && !flush_now && rd_en_i && !hit;

	// ############################
	// Fill and flush control
	// ############################
	always_ff @(posedge wb_clk_i) begin
		if (wb_rst_i) begin
			valid        <= '0;
			filling      <= 1'b0;
			flush_pend   <= 1'b0;
			fill_start_o <= 1'b0;
			fill_cnt     <= '0;
		end else begin
			fill_start_o <= 1'b0;

			if (!filling) begin
				if (flush_now) begin
					valid      <= '0;
					flush_pend <= 1'b0;
				end else if (start_fill) begin
					valid[req_idx] <= 1'b0;   // Line is being overwritten
					filling        <= 1'b1;
					fill_start_o   <= 1'b1;
					fill_cnt       <= '0;
				end
			end else begin
				if (flush_i)
					flush_pend <= 1'b1;     // Wait for the fill to end

				if (word_valid_i)
					fill_cnt <= fill_cnt + 1'b1;

				if (fill_done_i) begin
					filling <= 1'b0;
					if (flush_now) begin
						valid      <= '0;
						flush_pend <= 1'b0;
					end else begin
						valid[fill_idx] <= 1'b1;
					end
				end
			end
		end
	end

	// Tags, line data and the fill address
	always_ff @(posedge wb_clk_i) begin
		if (start_fill) begin
			tag_mem[req_idx] <= req_tag;
			fill_addr_o      <= {req_tag, req_idx, {INDEX_LSB{1'b0}}};
		end

		if (word_valid_i)
			data_mem[{fill_idx, fill_cnt}] <= word_data_i;
	end

endmodule

`default_nettype wire

// ==== design/spi_flash_reader.sv ====
`default_nettype none

module spi_flash_reader import flash_pkg::*; (
	input  wire                     wb_clk_i,
	input  wire                     wb_rst_i,

	// Fill request from the cache
	input  wire                     fill_start_i,
	input  wire  [FLASH_ADDR_W-1:0] fill_addr_i,
	output logic                    word_valid_o,
	output logic [DATA_W-1:0]       word_data_o,
	output logic                    fill_done_o,

	// SPI pins in mode 0
	output logic                    spi_sclk_o,
	output logic                    spi_cs_n_o,
	output logic                    spi_mosi_o,
	input  wire                     spi_miso_i
);

	logic [SPI_DIV_W-1:0]     div_cnt;
	logic [SPI_BIT_CNT_W-1:0] bit_cnt;      // Bits done in this transaction
	logic [SPI_BIT_CNT_W-1:0] data_bit;
	logic [SPI_HDR_W-1:0]     tx_sh;
	logic [BYTE_W-2:0]        rx_bits;

	logic half_tick;
	logic rise;
	logic fall;
	logic data_phase;
	logic last_bit;
	logic byte_end;
	logic word_end;

	// ############################
	// SCLK timing
	// ############################
	assign half_tick = !spi_cs_n_o && (div_cnt == SPI_DIV_W'(SPI_CLK_DIV - 1));
	assign rise      = half_tick && !spi_sclk_o;
	assign fall      = half_tick && spi_sclk_o;

	assign data_phase = bit_cnt >= SPI_BIT_CNT_W'(SPI_HDR_W);
	assign data_bit   = bit_cnt - SPI_BIT_CNT_W'(SPI_HDR_W);
	assign last_bit   = bit_cnt == SPI_BIT_CNT_W'(SPI_BITS - 1);
	assign byte_end   = data_phase && (data_bit[BYTE_BIT_W-1:0] == '1);
	assign word_end   = data_phase && (data_bit[WORD_BIT_W-1:0] == '1);

	assign spi_mosi_o = tx_sh[SPI_HDR_W-1];   // MSB first

	always_ff @(posedge wb_clk_i) begin
		if (wb_rst_i) begin
			spi_cs_n_o   <= 1'b1;
			spi_sclk_o   <= 1'b0;
			div_cnt      <= '0;
			bit_cnt      <= '0;
			tx_sh        <= '0;
			word_valid_o <= 1'b0;
			fill_done_o  <= 1'b0;
		end else begin
			word_valid_o <= 1'b0;
			fill_done_o  <= 1'b0;

			if (spi_cs_n_o) begin
				if (fill_start_i) begin
					spi_cs_n_o <= 1'b0;
					div_cnt    <= '0;
					bit_cnt    <= '0;
					tx_sh      <= {SPI_CMD_READ, fill_addr_i};
				end
			end else begin
				div_cnt <= half_tick ? '0 : div_cnt + 1'b1;

				if (rise) begin
					spi_sclk_o <= 1'b1;
					if (word_end)
						word_valid_o <= 1'b1;   // Last bit of a word sampled
				end

				if (fall) begin
					spi_sclk_o <= 1'b0;
					tx_sh      <= {tx_sh[SPI_HDR_W-2:0], 1'b0};
					bit_cnt    <= bit_cnt + 1'b1;
					if (last_bit) begin
						spi_cs_n_o  <= 1'b1;
						fill_done_o <= 1'b1;
					end
				end
			end
		end
	end

	// ############################
	// Receive path
	// ############################
	// First byte of a word ends up in bits 7:0
	always_ff @(posedge wb_clk_i) begin
		if (rise && data_phase) begin
			if (byte_end)
				word_data_o <= {rx_bits, spi_miso_i, word_data_o[DATA_W-1:BYTE_W]};
			else
				rx_bits <= {rx_bits[BYTE_W-3:0], spi_miso_i};
		end
	end

endmodule

`default_nettype wire

// ==== design/wb_flash_top.sv ====
`default_nettype none

module wb_flash_top import flash_pkg::*; (
	input  wire                     wb_clk_i,
	input  wire                     wb_rst_i,

	input  wire                     wb_cyc_i,
	input  wire                     wb_stb_i,
	input  wire                     wb_we_i,
	input  wire  [SEL_W-1:0]        wb_sel_i,
	input  wire  [FLASH_ADDR_W-1:0] wb_adr_i,
	input  wire  [DATA_W-1:0]       wb_data_i,
	output wire  [DATA_W-1:0]       wb_data_o,
	output wire                     wb_ack_o,
	output wire                     wb_stall_o,
	output wire                     wb_err_o,

	input  wire                     cache_flush_i,

	output wire                     spi_sclk_o,
	output wire                     spi_cs_n_o,
	output wire                     spi_mosi_o,
	input  wire                     spi_miso_i
);

	wire                    cache_rd_en;
	wire [FLASH_ADDR_W-1:0] cache_addr;
	wire [DATA_W-1:0]       cache_data;
	wire                    cache_busy;

	wire                    fill_start;
	wire [FLASH_ADDR_W-1:0] fill_addr;
	wire                    word_valid;
	wire [DATA_W-1:0]       word_data;
	wire                    fill_done;

	wb_flash_interface u_wb_if (
		.wb_clk_i      (wb_clk_i),
		.wb_rst_i      (wb_rst_i),
		.wb_cyc_i      (wb_cyc_i),
		.wb_stb_i      (wb_stb_i),
		.wb_we_i       (wb_we_i),
		.wb_sel_i      (wb_sel_i),
		.wb_adr_i      (wb_adr_i),
		.wb_data_i     (wb_data_i),
		.wb_data_o     (wb_data_o),
		.wb_ack_o      (wb_ack_o),
		.wb_stall_o    (wb_stall_o),
		.wb_err_o      (wb_err_o),
		.cache_rd_en_o (cache_rd_en),
		.cache_addr_o  (cache_addr),
		.cache_data_i  (cache_data),
		.cache_busy_i  (cache_busy)
	);

	flash_cache u_cache (
		.wb_clk_i     (wb_clk_i),
		.wb_rst_i     (wb_rst_i),
		.rd_en_i      (cache_rd_en),
		.addr_i       (cache_addr),
		.flush_i      (cache_flush_i),
		.data_o       (cache_data),
		.busy_o       (cache_busy),
		.fill_start_o (fill_start),
		.fill_addr_o  (fill_addr),
		.word_valid_i (word_valid),
		.word_data_i  (word_data),
		.fill_done_i  (fill_done)
	);

	spi_flash_reader u_spi (
		.wb_clk_i     (wb_clk_i),
		.wb_rst_i     (wb_rst_i),
		.fill_start_i (fill_start),
		.fill_addr_i  (fill_addr),
		.word_valid_o (word_valid),
		.word_data_o  (word_data),
		.fill_done_o  (fill_done),
		.spi_sclk_o   (spi_sclk_o),
		.spi_cs_n_o   (spi_cs_n_o),
		.spi_mosi_o   (spi_mosi_o),
		.spi_miso_i   (spi_miso_i)
	);

endmodule

`default_nettype wire

// ==== tests/spi_flash_model.sv ====
`default_nettype none

module spi_flash_model import flash_pkg::*; (
	input  wire                  sclk_i,
	input  wire                  cs_n_i,
	input  wire                  mosi_i,
	output logic                 miso_o,
	output int                   txn_count_o,   // Chip select fall events
	output logic [SPI_CMD_W-1:0] cmd_o          // Command byte of the last transaction
);

	logic [SPI_HDR_W-1:0] hdr;
	int                   bit_cnt;   // Rising SCLK edges since chip select fell

	// Flash contents are computed, not stored
	function automatic logic [BYTE_W-1:0] byte_at(input logic [FLASH_ADDR_W-1:0] addr);
		return addr[7:0] ^ addr[15:8];
	endfunction

	// Bit idx of the data stream from base with MSB first in each byte
	function automatic logic stream_bit(input logic [FLASH_ADDR_W-1:0] base, input int idx);
		logic [BYTE_W-1:0] b;
		b = byte_at(base + FLASH_ADDR_W'(idx / BYTE_W));
		b = b << (idx % BYTE_W);
		return b[BYTE_W-1];
	endfunction

	initial begin
		miso_o      = 1'b0;
		txn_count_o = 0;
	end

	always @(negedge cs_n_i) begin
		txn_count_o <= txn_count_o + 1;
	end

	// ##############################
	// Command and address sampled on the rising edge
	// ##############################
	always @(posedge sclk_i or posedge cs_n_i) begin
		if (cs_n_i) begin
			bit_cnt <= 0;
		end else begin
			if (bit_cnt < SPI_HDR_W)
				hdr <= {hdr[SPI_HDR_W-2:0], mosi_i};
			bit_cnt <= bit_cnt + 1;
		end
	end

	assign cmd_o = hdr[SPI_HDR_W-1:FLASH_ADDR_W];

	// ##############################
	// Read data shifted out on the falling edge
	// ##############################
	always @(negedge sclk_i) begin
		if (!cs_n_i && bit_cnt >= SPI_HDR_W)
			miso_o <= stream_bit(hdr[FLASH_ADDR_W-1:0], bit_cnt - SPI_HDR_W);
	end

endmodule

`default_nettype wire

// ==== tests/wb_flash_top_tb.sv ====
`default_nettype none

module wb_flash_top_tb import flash_pkg::*; ;

	localparam int          ACK_TIMEOUT  = 2000;   // Covers a full line fill
	localparam int          IDLE_TIMEOUT = 20;
	localparam logic [15:0] LFSR_SEED    = 16'd39;

	logic                    wb_clk_i = 1'b0;
	logic                    wb_rst_i;
	logic                    wb_cyc_i;
	logic                    wb_stb_i;
	logic                    wb_we_i;
	logic [SEL_W-1:0]        wb_sel_i;
	logic [FLASH_ADDR_W-1:0] wb_adr_i;
	logic [DATA_W-1:0]       wb_data_i;
	wire  [DATA_W-1:0]       wb_data_o;
	wire                     wb_ack_o;
	wire                     wb_stall_o;
	wire                     wb_err_o;
	logic                    cache_flush_i;
	wire                     spi_sclk;
	wire                     spi_cs_n;
	wire                     spi_mosi;
	wire                     spi_miso;
	int                      txn_count;
	wire  [SPI_CMD_W-1:0]    flash_cmd;

	int          checks;
	int          errors;
	int          timeouts;
	logic [15:0] lfsr;

	always #5 wb_clk_i = ~wb_clk_i;

	wb_flash_top dut (
		.wb_clk_i      (wb_clk_i),
		.wb_rst_i      (wb_rst_i),
		.wb_cyc_i      (wb_cyc_i),
		.wb_stb_i      (wb_stb_i),
		.wb_we_i       (wb_we_i),
		.wb_sel_i      (wb_sel_i),
		.wb_adr_i      (wb_adr_i),
		.wb_data_i     (wb_data_i),
		.wb_data_o     (wb_data_o),
		.wb_ack_o      (wb_ack_o),
		.wb_stall_o    (wb_stall_o),
		.wb_err_o      (wb_err_o),
		.cache_flush_i (cache_flush_i),
		.spi_sclk_o    (spi_sclk),
		.spi_cs_n_o    (spi_cs_n),
		.spi_mosi_o    (spi_mosi),
		.spi_miso_i    (spi_miso)
	);

	spi_flash_model u_flash (
		.sclk_i      (spi_sclk),
		.cs_n_i      (spi_cs_n),
		.mosi_i      (spi_mosi),
		.miso_o      (spi_miso),
		.txn_count_o (txn_count),
		.cmd_o       (flash_cmd)
	);

	// ##############################
	// Stimulus helpers
	// ##############################
	// Taps 16, 14, 13, 11
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			v    = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	// Four flash bytes from the word-aligned address with the first byte lowest
	function automatic logic [DATA_W-1:0] expected_word(input logic [FLASH_ADDR_W-1:0] addr);
		logic [FLASH_ADDR_W-1:0] a;
		logic [DATA_W-1:0]       w;
		w = '0;
		for (int b = 0; b < SEL_W; b++) begin
			a = {addr[FLASH_ADDR_W-1:BYTE_OFF_W], {BYTE_OFF_W{1'b0}}} + FLASH_ADDR_W'(b);
			w = {a[7:0] ^ a[15:8], w[DATA_W-1:BYTE_W]};
		end
		return w;
	endfunction

	task automatic check_int(input string what, input int got, input int exp);
		checks++;
		assert (got == exp) else begin
			errors++;
			$display("** Error at %0t: %s is %0d, expected %0d", $time, what, got, exp);
		end
	endtask

	task automatic check_word(input string what, input logic [DATA_W-1:0] got,
			input logic [DATA_W-1:0] exp);
		checks++;
		assert (got == exp) else begin
			errors++;
			$display("** Error at %0t: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic wait_idle();
		int n;
		@(negedge wb_clk_i);
		n = 0;
		while ((wb_stall_o || wb_ack_o || wb_err_o) && n < IDLE_TIMEOUT) begin
			@(negedge wb_clk_i);
			n++;
		end
		if (n >= IDLE_TIMEOUT) begin
			timeouts++;
			$display("Timeout at %0t: the slave never returned to idle", $time);
		end
	endtask

	// One Wishbone request; lat counts falling edges from acceptance to the response
	task automatic wb_cycle(input logic we, input logic [FLASH_ADDR_W-1:0] addr,
			output logic [DATA_W-1:0] rdata, output logic got_ack,
			output logic got_err, output int lat);
		int n;
		wait_idle();
		wb_cyc_i  = 1'b1;
		wb_stb_i  = 1'b1;
		wb_we_i   = we;
		wb_adr_i  = addr;
		wb_data_i = rand_bits(32);
		@(posedge wb_clk_i);   // Accepting edge
		n       = 0;
		got_ack = 1'b0;
		got_err = 1'b0;
		rdata   = '0;
		while (!got_ack && !got_err && n < ACK_TIMEOUT) begin
			@(negedge wb_clk_i);
			n++;
			if (n == 1)
				check_int("stall after acceptance", int'(wb_stall_o), 1);
			got_ack = wb_ack_o;
			got_err = wb_err_o;
			rdata   = wb_data_o;
		end
		lat      = n;
		wb_cyc_i = 1'b0;
		wb_stb_i = 1'b0;
		wb_we_i  = 1'b0;
		if (!got_ack && !got_err) begin
			timeouts++;
			$display("Timeout at %0t: no ack or err for address %h", $time, addr);
		end
	endtask

	task automatic read_check(input string what, input logic [FLASH_ADDR_W-1:0] addr,
			input int new_txns, input bit hit);
		logic [DATA_W-1:0] rdata;
		logic              ack;
		logic              err;
		int                lat;
		int                count0;
		count0 = txn_count;
		wb_cycle(1'b0, addr, rdata, ack, err, lat);
		check_int({what, " ack"}, int'(ack), 1);
		check_int({what, " err"}, int'(err), 0);
		check_word({what, " data"}, rdata, expected_word(addr));
		check_int({what, " new transactions"}, txn_count - count0, new_txns);
		if (hit)
			check_int({what, " latency"}, lat, 2);
		if (new_txns > 0)
			check_int({what, " command"}, int'(flash_cmd), int'(SPI_CMD_READ));
	endtask

	// ##############################
	// Test sequence
	// ##############################
	initial begin
		logic [FLASH_ADDR_W-1:0] addr_a;
		logic [FLASH_ADDR_W-1:0] addr_b;
		logic [FLASH_ADDR_W-1:0] line_base;
		logic [DATA_W-1:0]       rdata;
		logic                    ack;
		logic                    err;
		int                      lat;
		int                      count0;

		checks        = 0;
		errors        = 0;
		timeouts      = 0;
		lfsr          = LFSR_SEED;
		wb_rst_i      = 1'b1;
		wb_cyc_i      = 1'b0;
		wb_stb_i      = 1'b0;
		wb_we_i       = 1'b0;
		wb_sel_i      = '1;
		wb_adr_i      = '0;
		wb_data_i     = '0;
		cache_flush_i = 1'b0;
		repeat (10) @(negedge wb_clk_i);
		wb_rst_i = 1'b0;
		@(negedge wb_clk_i);

		check_int("ack after reset", int'(wb_ack_o), 0);
		check_int("err after reset", int'(wb_err_o), 0);
		check_int("stall after reset", int'(wb_stall_o), 0);
		check_int("cs_n after reset", int'(spi_cs_n), 1);

		// First read fills the line
		addr_a = FLASH_ADDR_W'(rand_bits(FLASH_ADDR_W));
		read_check("first read", addr_a, 1, 1'b0);

		line_base = {addr_a[FLASH_ADDR_W-1:INDEX_LSB], {INDEX_LSB{1'b0}}};
		for (int k = 0; k < LINE_WORDS; k++) begin
			if (OFFSET_W'(k) != addr_a[INDEX_LSB-1:OFFSET_LSB])
				read_check("line read", line_base + FLASH_ADDR_W'(k * SEL_W), 0, 1'b1);
		end

		// Writes are rejected and leave the cache alone
		count0 = txn_count;
		wb_cycle(1'b1, addr_a, rdata, ack, err, lat);
		check_int("write err", int'(err), 1);
		check_int("write ack", int'(ack), 0);
		check_int("write latency", lat, 2);
		check_int("write transactions", txn_count - count0, 0);
		read_check("read after write", addr_a, 0, 1'b1);

		// Same index with a different tag bit in the byte that also shapes the data
		addr_b = addr_a ^ (FLASH_ADDR_W'(1) << (TAG_LSB + int'(rand_bits(3))));
		read_check("conflict read", addr_b, 1, 1'b0);
		read_check("evicted read", addr_a, 1, 1'b0);

		@(negedge wb_clk_i);
		cache_flush_i = 1'b1;
		@(negedge wb_clk_i);
		cache_flush_i = 1'b0;
		read_check("read after flush", addr_a, 1, 1'b0);

		$display("Checks: %0d, errors: %0d, timeouts: %0d", checks, errors, timeouts);
		if (errors == 0 && timeouts == 0 && checks > 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== wb_flash_top.f ====
design/flash_pkg.sv
design/wb_flash_interface.sv
design/flash_cache.sv
design/spi_flash_reader.sv
design/wb_flash_top.sv
tests/spi_flash_model.sv
tests/wb_flash_top_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the flash window testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -j 0 \
	--top-module wb_flash_top_tb \
	-f wb_flash_top.f \
	-o sim_wb_flash

./obj_dir/sim_wb_flash | tee sim.log

if grep -qx "Everything OK" sim.log; then
	echo "Simulation passed"
	exit 0
else
	echo "Simulation failed"
	exit 1
fi
